/* hw/pmem_access_timer.sv */
`timescale 1ns/1ps

module pmem_access_timer #(
    parameter int CNT_W = 2
) (
    input  logic             bus_clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [CNT_W-1:0] count,
    output logic             busy,
    output logic             done
);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (start) begin
            cnt_q <= count;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign busy = (cnt_q != '0);

    // last counted cycle, the counter hits zero at its end.
    assign done = (cnt_q == CNT_W'(1));

    a_no_restart: assert property (
        @(posedge bus_clk) disable iff (!rst_n) start |-> !busy
    );

endmodule

/* hw/pmem_bank_array.sv */
`timescale 1ns/1ps

module pmem_bank_array (
    input  logic                 bus_clk,
    input  logic                 mem_en,
    input  logic                 mem_we,
    input  pmem_pkg::line_addr_t mem_addr,
    input  pmem_pkg::line_t      mem_wdata,
    output pmem_pkg::line_t      mem_rdata
);

    localparam int DEPTH = 2 ** $bits(pmem_pkg::line_addr_t);

    pmem_pkg::line_t mem [DEPTH];

    always_ff @(posedge bus_clk) begin
        if (mem_en && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // read data only moves while enabled, so it holds for the serializer.
    always_ff @(posedge bus_clk) begin
        if (mem_en && !mem_we) begin
            mem_rdata <= mem[mem_addr];
        end
    end

endmodule

/* hw/pmem_bank_ctrl.sv */
`timescale 1ns/1ps

`include "pmem_params.svh"

module pmem_bank_ctrl #(
    parameter int CNT_W = 2
) (
    input  logic                 bus_clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  pmem_pkg::req_t       req,
    input  logic                 ser_idle,
    input  logic                 rel,
    input  logic                 timer_done,
    output logic                 timer_start,
    output logic [CNT_W-1:0]     timer_count,
    output logic                 mem_en,
    output logic                 mem_we,
    output pmem_pkg::line_addr_t mem_addr,
    output pmem_pkg::line_t      mem_wdata,
    output logic                 resp_valid,
    output pmem_pkg::pmem_op_t   resp_op,
    output pmem_pkg::line_addr_t resp_addr,
    output pmem_pkg::bus_id_t    resp_src,
    output logic                 done_req
);

    pmem_pkg::ctrl_state_t state_q;
    pmem_pkg::req_t        req_q;
    logic                  handed_q;

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= pmem_pkg::IDLE;
            handed_q <= 1'b0;
        end else begin
            case (state_q)
                pmem_pkg::IDLE: begin
                    if (req_valid) begin
                        state_q <= pmem_pkg::SETUP;
                    end
                end
                pmem_pkg::SETUP: begin
                    state_q <= pmem_pkg::ACCESS;
                end
                pmem_pkg::ACCESS: begin
                    if (timer_done) begin
                        state_q <= pmem_pkg::HANDOFF;
                    end
                end
                default: begin
                    // hold the bank until the serializer releases the bus.
                    if (!handed_q && ser_idle) begin
                        handed_q <= 1'b1;
                    end else if (handed_q && rel) begin
                        handed_q <= 1'b0;
                        state_q  <= pmem_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge bus_clk) begin
        if (state_q == pmem_pkg::IDLE && req_valid) begin
            req_q <= req;
        end
    end

    assign timer_start = (state_q == pmem_pkg::SETUP);
    assign timer_count = CNT_W'(`PMEM_ACCESS_CYCLES);

    assign mem_en    = (state_q == pmem_pkg::ACCESS);
    assign mem_we    = mem_en && (req_q.op == pmem_pkg::OP_WRITE);
    assign mem_addr  = req_q.addr;
    assign mem_wdata = req_q.wdata;

    assign resp_valid = (state_q == pmem_pkg::HANDOFF) && !handed_q && ser_idle;
    assign resp_op    = req_q.op;
    assign resp_addr  = req_q.addr;
    assign resp_src   = req_q.src;
    assign done_req   = (state_q == pmem_pkg::HANDOFF) && handed_q && rel;

endmodule

/* hw/pmem_deser.sv */
`timescale 1ns/1ps

module pmem_deser #(
    parameter int BANK_INDEX = 0
) (
    input  logic            bus_clk,
    input  logic            rst_n,
    input  pmem_pkg::beat_t bus_in,
    input  logic            done_req,
    output logic            free,
    output logic            req_valid,
    output pmem_pkg::req_t  req
);

    localparam int BW = $bits(pmem_pkg::beat_data_t);

    logic           take;
    logic           mid_q;
    logic           half_q;
    pmem_pkg::hdr_t hdr;

    assign take = bus_in.valid && (bus_in.bank == pmem_pkg::bank_sel_t'(BANK_INDEX));
    assign hdr  = pmem_pkg::hdr_t'(bus_in.data[$bits(pmem_pkg::hdr_t)-1:0]);

    // mid_q is set between a write header and its last data beat.
    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            free      <= 1'b1;
            mid_q     <= 1'b0;
            half_q    <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            if (done_req) begin
                free <= 1'b1;
            end
            if (take) begin
                if (!mid_q) begin
                    free <= 1'b0;
                    if (bus_in.last) begin
                        req_valid <= 1'b1;
                    end else begin
                        mid_q  <= 1'b1;
                        half_q <= 1'b0;
                    end
                end else begin
                    half_q <= 1'b1;
                    if (bus_in.last) begin
                        mid_q     <= 1'b0;
                        req_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (take && !mid_q) begin
            req.op   <= hdr.op;
            req.addr <= hdr.addr;
            req.src  <= hdr.src;
        end
        // low half arrives first.
        if (take && mid_q) begin
            if (!half_q) begin
                req.wdata[BW-1:0] <= bus_in.data;
            end else begin
                req.wdata[2*BW-1:BW] <= bus_in.data;
            end
        end
    end

    a_no_beat_while_busy: assert property (
        @(posedge bus_clk) disable iff (!rst_n) take |-> (free || mid_q)
    );

endmodule

/* hw/pmem_params.svh */
`ifndef PMEM_PARAMS_SVH
`define PMEM_PARAMS_SVH

// number of independent banks on the bus.
`define PMEM_NUM_BANKS 4

// line index width within one bank, 512 lines.
`define PMEM_LINE_AW 9

// payload width of one bus beat.
`define PMEM_BEAT_W 64

// cycles the storage enable is held per access.
`define PMEM_ACCESS_CYCLES 3

// bus id of bank 0, bank i answers as this plus i.
`define PMEM_FIRST_BANK_ID 8

`endif

/* hw/pmem_pkg.sv */
`include "pmem_params.svh"

package pmem_pkg;

    typedef logic [`PMEM_LINE_AW-1:0] line_addr_t;
    typedef logic [2*`PMEM_BEAT_W-1:0] line_t;
    typedef logic [`PMEM_BEAT_W-1:0] beat_data_t;
    typedef logic [3:0] bus_id_t;
    typedef logic [$clog2(`PMEM_NUM_BANKS)-1:0] bank_sel_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } pmem_op_t;

    // one cycle on either bus.
    typedef struct packed {
        logic       valid;
        bank_sel_t  bank;
        logic       last;
        beat_data_t data;
    } beat_t;

    // sits in the low bits of a header beat.
    typedef struct packed {
        pmem_op_t   op;
        line_addr_t addr;
        bus_id_t    src;
    } hdr_t;

    typedef struct packed {
        pmem_op_t   op;
        line_addr_t addr;
        bus_id_t    src;
        line_t      wdata;
    } req_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        HANDOFF
    } ctrl_state_t;

endpackage

/* hw/pmem_ser.sv */
`timescale 1ns/1ps

`include "pmem_params.svh"

module pmem_ser #(
    parameter int BANK_INDEX = 0
) (
    input  logic                 bus_clk,
    input  logic                 rst_n,
    input  logic                 resp_valid,
    input  pmem_pkg::pmem_op_t   resp_op,
    input  pmem_pkg::line_addr_t resp_addr,
    input  pmem_pkg::bus_id_t    resp_src,
    input  pmem_pkg::line_t      resp_data,
    input  logic                 grant,
    input  logic                 ack,
    output logic                 idle,
    output logic                 req,
    output logic                 rel,
    output pmem_pkg::beat_t      beat
);

    localparam pmem_pkg::bus_id_t BANK_ID = pmem_pkg::bus_id_t'(`PMEM_FIRST_BANK_ID + BANK_INDEX);
    localparam int HW = $bits(pmem_pkg::hdr_t);
    localparam int IW = $bits(pmem_pkg::bus_id_t);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEND,
        S_WAIT,
        S_REL
    } ser_state_t;

    ser_state_t           state_q;
    logic [1:0]           idx_q;
    logic [1:0]           last_idx;
    pmem_pkg::pmem_op_t   op_q;
    pmem_pkg::line_addr_t addr_q;
    pmem_pkg::bus_id_t    dest_q;
    pmem_pkg::line_t      data_q;
    pmem_pkg::hdr_t       hdr;

    assign last_idx = (op_q == pmem_pkg::OP_READ) ? 2'd2 : 2'd0;

    always_ff @(posedge bus_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (resp_valid) begin
                        state_q <= S_SEND;
                        idx_q   <= '0;
                    end
                end
                S_SEND: begin
                    if (grant) begin
                        if (idx_q == last_idx) begin
                            state_q <= S_WAIT;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                S_WAIT: begin
                    if (ack) begin
                        state_q <= S_REL;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge bus_clk) begin
        if (state_q == S_IDLE && resp_valid) begin
            op_q   <= resp_op;
            addr_q <= resp_addr;
            dest_q <= resp_src;
            data_q <= resp_data;
        end
    end

    assign idle = (state_q == S_IDLE);
    assign req  = (state_q == S_SEND) || (state_q == S_WAIT);
    assign rel  = (state_q == S_REL);

    assign hdr.op   = op_q;
    assign hdr.addr = addr_q;
    assign hdr.src  = BANK_ID;

    // header beat carries the requester id just above the header fields.
    always_comb begin
        beat       = '0;
        beat.valid = (state_q == S_SEND) && grant;
        beat.bank  = pmem_pkg::bank_sel_t'(BANK_INDEX);
        beat.last  = (idx_q == last_idx);
        case (idx_q)
            2'd0: begin
                beat.data[HW-1:0]  = hdr;
                beat.data[HW+:IW]  = dest_q;
            end
            2'd1: beat.data = data_q[`PMEM_BEAT_W-1:0];
            default: beat.data = data_q[2*`PMEM_BEAT_W-1:`PMEM_BEAT_W];
        endcase
    end

    a_grant_needs_req: assert property (
        @(posedge bus_clk) disable iff (!rst_n) grant |-> req
    );

endmodule

/* hw/pmem_top.sv */
`timescale 1ns/1ps

`include "pmem_params.svh"

module pmem_top (
    input  logic                       bus_clk,
    input  logic                       rst_n,
    input  pmem_pkg::beat_t            bus_in,
    input  logic [`PMEM_NUM_BANKS-1:0] grant,
    input  logic [`PMEM_NUM_BANKS-1:0] ack,
    output logic [`PMEM_NUM_BANKS-1:0] free,
    output logic [`PMEM_NUM_BANKS-1:0] req,
    output logic [`PMEM_NUM_BANKS-1:0] rel,
    output pmem_pkg::beat_t            bus_out
);

    localparam int TIMER_W = $clog2(`PMEM_ACCESS_CYCLES + 1);

    pmem_pkg::beat_t ser_beat [`PMEM_NUM_BANKS];

    genvar i;
    generate
        for (i = 0; i < `PMEM_NUM_BANKS; i = i + 1) begin : g_bank
            logic                 req_valid;
            pmem_pkg::req_t       bank_req;
            logic                 done_req;
            logic                 ser_idle;
            logic                 timer_start;
            logic [TIMER_W-1:0]   timer_count;
            logic                 timer_done;
            logic                 mem_en;
            logic                 mem_we;
            pmem_pkg::line_addr_t mem_addr;
            pmem_pkg::line_t      mem_wdata;
            pmem_pkg::line_t      mem_rdata;
            logic                 resp_valid;
            pmem_pkg::pmem_op_t   resp_op;
            pmem_pkg::line_addr_t resp_addr;
            pmem_pkg::bus_id_t    resp_src;

            pmem_deser #(.BANK_INDEX(i)) u_deser (
                .bus_clk(bus_clk), .rst_n(rst_n), .bus_in(bus_in), .done_req(done_req),
                .free(free[i]), .req_valid(req_valid), .req(bank_req)
            );

            pmem_access_timer #(.CNT_W(TIMER_W)) u_timer (
                .bus_clk(bus_clk), .rst_n(rst_n), .start(timer_start), .count(timer_count),
                .busy(), .done(timer_done)
            );

            pmem_bank_ctrl #(.CNT_W(TIMER_W)) u_ctrl (
                .bus_clk(bus_clk), .rst_n(rst_n), .req_valid(req_valid), .req(bank_req),
                .ser_idle(ser_idle), .rel(rel[i]), .timer_done(timer_done),
                .timer_start(timer_start), .timer_count(timer_count),
                .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
                .resp_valid(resp_valid), .resp_op(resp_op), .resp_addr(resp_addr),
                .resp_src(resp_src), .done_req(done_req)
            );

            pmem_bank_array u_array (
                .bus_clk(bus_clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
                .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
            );

            pmem_ser #(.BANK_INDEX(i)) u_ser (
                .bus_clk(bus_clk), .rst_n(rst_n), .resp_valid(resp_valid), .resp_op(resp_op),
                .resp_addr(resp_addr), .resp_src(resp_src), .resp_data(mem_rdata),
                .grant(grant[i]), .ack(ack[i]), .idle(ser_idle), .req(req[i]), .rel(rel[i]),
                .beat(ser_beat[i])
            );
        end
    endgenerate

    // the arbiter grants one bank at a time.
    always_comb begin
        bus_out = '0;
        for (int b = 0; b < `PMEM_NUM_BANKS; b++) begin
            if (grant[b]) begin
                bus_out = ser_beat[b];
            end
        end
    end

endmodule

/* pmem_top.f */
+incdir+hw
hw/pmem_pkg.sv
hw/pmem_deser.sv
hw/pmem_access_timer.sv
hw/pmem_bank_ctrl.sv
hw/pmem_bank_array.sv
hw/pmem_ser.sv
hw/pmem_top.sv
testbench/pmem_tb.sv

/* run_sim.sh */
#!/bin/sh
# compiles the pmem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module pmem_tb \
    --Mdir "$BUILD_DIR" \
    -o pmem_sim \
    -f pmem_top.f
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

"./$BUILD_DIR/pmem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

/* testbench/pmem_tb.sv */
`timescale 1ns/1ps

`include "pmem_params.svh"

module pmem_tb;

    localparam int NB          = `PMEM_NUM_BANKS;
    localparam int NUM_OPS     = 14;
    localparam int CYCLE_LIMIT = NUM_OPS * 40;
    localparam int HDR_W       = $bits(pmem_pkg::hdr_t);
    localparam int ID_W        = $bits(pmem_pkg::bus_id_t);
    localparam int BW          = `PMEM_BEAT_W;
    localparam pmem_pkg::bus_id_t TB_ID = 4'h3;

    // pair sends this row and the next before either response is served.
    typedef struct packed {
        pmem_pkg::bank_sel_t  bank;
        pmem_pkg::pmem_op_t   op;
        pmem_pkg::line_addr_t addr;
        logic                 rd_check;
        logic                 pair;
    } op_entry_t;

    logic            bus_clk;
    logic            rst_n;
    pmem_pkg::beat_t bus_in;
    logic [NB-1:0]   grant;
    logic [NB-1:0]   ack;
    logic [NB-1:0]   free;
    logic [NB-1:0]   req;
    logic [NB-1:0]   rel;
    pmem_pkg::beat_t bus_out;
    pmem_pkg::line_t ref_mem [NB][2**`PMEM_LINE_AW];
    int              cycle_count = 0;

    op_entry_t ops [NUM_OPS] = '{
        '{2'd0, pmem_pkg::OP_WRITE, 9'h010, 1'b0, 1'b0},
        '{2'd0, pmem_pkg::OP_READ,  9'h010, 1'b1, 1'b0},
        '{2'd0, pmem_pkg::OP_WRITE, 9'h155, 1'b0, 1'b0},
        '{2'd1, pmem_pkg::OP_WRITE, 9'h155, 1'b0, 1'b0},
        '{2'd2, pmem_pkg::OP_WRITE, 9'h155, 1'b0, 1'b0},
        '{2'd3, pmem_pkg::OP_WRITE, 9'h155, 1'b0, 1'b0},
        '{2'd3, pmem_pkg::OP_READ,  9'h155, 1'b1, 1'b0},
        '{2'd2, pmem_pkg::OP_READ,  9'h155, 1'b1, 1'b0},
        '{2'd1, pmem_pkg::OP_READ,  9'h155, 1'b1, 1'b0},
        '{2'd0, pmem_pkg::OP_READ,  9'h155, 1'b1, 1'b0},
        '{2'd1, pmem_pkg::OP_WRITE, 9'h0a3, 1'b0, 1'b1},
        '{2'd2, pmem_pkg::OP_WRITE, 9'h1ff, 1'b0, 1'b0},
        '{2'd1, pmem_pkg::OP_READ,  9'h0a3, 1'b1, 1'b1},
        '{2'd2, pmem_pkg::OP_READ,  9'h1ff, 1'b1, 1'b0}
    };

    pmem_top dut (
        .bus_clk(bus_clk), .rst_n(rst_n), .bus_in(bus_in), .grant(grant), .ack(ack),
        .free(free), .req(req), .rel(rel), .bus_out(bus_out)
    );

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic tick();
        @(posedge bus_clk);
        #1;
    endtask

    task automatic send_request(input int idx);
        op_entry_t       e;
        pmem_pkg::hdr_t  hdr;
        pmem_pkg::line_t wdata;
        e        = ops[idx];
        hdr.op   = e.op;
        hdr.addr = e.addr;
        hdr.src  = TB_ID;
        wdata    = '0;
        tick();
        while (free[e.bank] !== 1'b1) begin
            tick();
        end
        bus_in                 = '0;
        bus_in.valid           = 1'b1;
        bus_in.bank            = e.bank;
        bus_in.last            = (e.op == pmem_pkg::OP_READ);
        bus_in.data[HDR_W-1:0] = hdr;
        tick();
        if (e.op == pmem_pkg::OP_WRITE) begin
            wdata = {$urandom, $urandom, $urandom, $urandom};
            ref_mem[e.bank][e.addr] = wdata;
            bus_in.data = wdata[BW-1:0];
        end else begin
            bus_in = '0;
        end
        // free drops in the cycle after the header.
        @(negedge bus_clk);
        check_value($sformatf("free[%0d]", e.bank), 128'(free[e.bank]), 128'(1'b0));
        if (e.op == pmem_pkg::OP_WRITE) begin
            tick();
            bus_in.data = wdata[2*BW-1:BW];
            bus_in.last = 1'b1;
            tick();
            bus_in = '0;
        end
    endtask

    task automatic serve_response(input int idx);
        op_entry_t       e;
        pmem_pkg::hdr_t  got_hdr;
        pmem_pkg::line_t exp_line;
        logic [NB-1:0]   bank_bit;
        int              nbeats;
        int              gdelay;
        int              adelay;
        e        = ops[idx];
        bank_bit = NB'(1) << e.bank;
        nbeats   = e.rd_check ? 3 : 1;
        exp_line = ref_mem[e.bank][e.addr];
        gdelay   = $urandom_range(5, 0);
        adelay   = $urandom_range(5, 0);
        @(negedge bus_clk);
        while (req[e.bank] !== 1'b1) begin
            @(negedge bus_clk);
        end
        // the pending response must hold while the grant is withheld.
        repeat (gdelay) begin
            tick();
            @(negedge bus_clk);
            check_value("req", 128'(req & bank_bit), 128'(bank_bit));
            check_value("bus_out.valid", 128'(bus_out.valid), 128'(1'b0));
        end
        tick();
        grant = bank_bit;
        for (int k = 0; k < nbeats; k++) begin
            if (k > 0) begin
                tick();
            end
            @(negedge bus_clk);
            check_value("bus_out.valid", 128'(bus_out.valid), 128'(1'b1));
            check_value("bus_out.bank", 128'(bus_out.bank), 128'(e.bank));
            check_value("bus_out.last", 128'(bus_out.last), 128'(k == nbeats - 1));
            if (k == 0) begin
                got_hdr = pmem_pkg::hdr_t'(bus_out.data[HDR_W-1:0]);
                check_value("bus_out.hdr.op", 128'(got_hdr.op), 128'(e.op));
                check_value("bus_out.hdr.addr", 128'(got_hdr.addr), 128'(e.addr));
                check_value("bus_out.hdr.src", 128'(got_hdr.src),
                            128'(`PMEM_FIRST_BANK_ID + e.bank));
                check_value("bus_out.hdr.dest", 128'(bus_out.data[HDR_W+:ID_W]), 128'(TB_ID));
            end else if (k == 1) begin
                check_value("bus_out.data", 128'(bus_out.data), 128'(exp_line[BW-1:0]));
            end else begin
                check_value("bus_out.data", 128'(bus_out.data), 128'(exp_line[2*BW-1:BW]));
            end
        end
        tick();
        grant = '0;
        @(negedge bus_clk);
        check_value("bus_out.valid", 128'(bus_out.valid), 128'(1'b0));
        repeat (adelay) begin
            tick();
            @(negedge bus_clk);
            check_value("req", 128'(req & bank_bit), 128'(bank_bit));
            check_value("rel", 128'(rel), 128'(0));
        end
        tick();
        ack = bank_bit;
        @(negedge bus_clk);
        check_value("rel", 128'(rel), 128'(0));
        tick();
        ack = '0;
        @(negedge bus_clk);
        check_value("rel", 128'(rel), 128'(bank_bit));
        check_value("req", 128'(req & bank_bit), 128'(0));
        check_value("free", 128'(free & bank_bit), 128'(0));
        tick();
        @(negedge bus_clk);
        check_value("rel", 128'(rel), 128'(0));
        check_value("free", 128'(free & bank_bit), 128'(bank_bit));
    endtask

    initial begin
        bus_clk = 1'b0;
        forever begin
            #2 bus_clk = ~bus_clk;
        end
    end

    initial begin
        forever begin
            @(posedge bus_clk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("Verification failed");
                $fatal(1, "cycle limit reached");
            end
        end
    end

    initial begin
        int idx;
        void'($urandom(32'h4e9c_e66a));
        rst_n  = 1'b0;
        bus_in = '0;
        grant  = '0;
        ack    = '0;
        repeat (8) @(posedge bus_clk);
        #1;
        rst_n = 1'b1;
        @(negedge bus_clk);
        check_value("free", 128'(free), 128'({NB{1'b1}}));
        check_value("req", 128'(req), 128'(0));
        check_value("rel", 128'(rel), 128'(0));
        check_value("bus_out.valid", 128'(bus_out.valid), 128'(1'b0));
        idx = 0;
        while (idx < NUM_OPS) begin
            if (ops[idx].pair && idx + 1 < NUM_OPS) begin
                send_request(idx);
                send_request(idx + 1);
                serve_response(idx);
                serve_response(idx + 1);
                idx += 2;
            end else begin
                send_request(idx);
                serve_response(idx);
                idx += 1;
            end
        end
        tick();
        $display("Verification passed");
        $finish;
    end

endmodule
